//--- project.f
verilog/ctrl_pkg.sv
verilog/opb_decode.sv
verilog/pulse_gen.sv
verilog/osc_counter.sv
verilog/scratch_pad.sv
verilog/watchdog.sv
verilog/ctrl_top.sv
test/ctrl_top_sva.sv
test/tb_ctrl_top.sv

//--- run.sh
#!/usr/bin/env bash
cd "$(dirname "$0")" \
    && verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module tb_ctrl_top -f project.f \
    && ./obj_dir/Vtb_ctrl_top \
    || exit 1

//--- test/tb_ctrl_top.sv
`timescale 1ns/1ps

module tb_ctrl_top import ctrl_pkg::*; ();

    // ------------------------------------------------------------------------
    // Test sizes and run limit
    // ------------------------------------------------------------------------
    localparam int RST_CYCLES  = 5;
    localparam int N_SP_OPS    = 300;                    // Random scratchpad accesses
    localparam int N_UNMAPPED  = 40;
    localparam int N_OSC_EDGES = 6;                      // Ref edges driven
    localparam int MAX_PERIOD  = 19;                     // Ref period range 4..19
    localparam int MAX_DIV     = 9;                      // Divider test range 0..9
    localparam int MAX_WD_DIV  = 5;                      // Watchdog test range 2..5
    localparam int LEN_RESET   = 20;
    localparam int LEN_SP      = 3 * N_SP_OPS + 20;
    localparam int LEN_MAP     = 2 * N_UNMAPPED + 20;
    localparam int LEN_OSC     = N_OSC_EDGES * MAX_PERIOD + 30;
    localparam int LEN_DIV     = 2 * (3 * DECADE * DECADE * MAX_DIV + 40);
    localparam int LEN_WD      = 2 * WD_PULSES * DECADE * DECADE * MAX_WD_DIV + 40;
    localparam int CYCLE_LIMIT = 2 * (RST_CYCLES + LEN_RESET + LEN_SP + LEN_MAP
                                      + LEN_OSC + LEN_DIV + LEN_WD);

    localparam int EV_20K = 0;                           // Event selectors
    localparam int EV_2K  = 1;
    localparam int EV_WD  = 2;

    logic  sys_clk = 1'b0;
    logic  rst;
    addr_t opb_addr;
    data_t opb_wdata;
    logic  opb_we;
    logic  opb_re;
    data_t opb_rdata;
    logic  opb_rvalid;
    logic  ref_clk;
    logic  wd_trig;
    logic  dbg_clk_20khz;
    logic  dbg_clk_2khz;

    int               cycles = 0;                        // Cycles since time zero
    logic [31:0]      rng_state;
    data_t            exp_q[$];                          // Expected words of reads in flight
    data_t            exp_word;
    data_t            m_sp1;                             // Register model
    data_t            m_sp2;
    logic [DIV_W-1:0] m_div;
    data_t            m_period;
    data_t            m_edges;

    always #50 sys_clk = ~sys_clk;                       // 100 ns period

    ctrl_top DUT (
        .sys_clk       (sys_clk),
        .rst           (rst),
        .opb_addr      (opb_addr),
        .opb_wdata     (opb_wdata),
        .opb_we        (opb_we),
        .opb_re        (opb_re),
        .opb_rdata     (opb_rdata),
        .opb_rvalid    (opb_rvalid),
        .ref_clk       (ref_clk),
        .wd_trig       (wd_trig),
        .dbg_clk_20khz (dbg_clk_20khz),
        .dbg_clk_2khz  (dbg_clk_2khz)
    );

    // ------------------------------------------------------------------------
    // Helpers
    // ------------------------------------------------------------------------
    task automatic stop_run(input string why);
        $display("ERROR: %s", why);
        $display("SOME TESTS FAILED");
        $fatal(1, "run stopped");
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("FAIL %s: got 0x%08h, expected 0x%08h", name, got, exp);
            $display("SOME TESTS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic logic [31:0] rand32();
        rng_state = xorshift(rng_state);
        return rng_state;
    endfunction

    function automatic data_t expected_read(input addr_t a);
        case (a)
            ADDR_SP1:        return m_sp1;
            ADDR_SP2:        return m_sp2;
            ADDR_CLK_DIV:    return {16'h0000, m_div};
            ADDR_OSC_PERIOD: return m_period;
            ADDR_OSC_EDGES:  return m_edges;
            ADDR_VERSION:    return VERSION_ID;
            default:         return UNMAPPED_DATA;
        endcase
    endfunction

    // Bus tasks drive one cycle each, model follows the write
    task automatic bus_write(input addr_t a, input data_t d);
        @(negedge sys_clk);
        opb_addr  = a;
        opb_wdata = d;
        opb_we    = 1'b1;
        opb_re    = 1'b0;
        if (a == ADDR_SP1) m_sp1 = d;
        if (a == ADDR_SP2) m_sp2 = d;
        if (a == ADDR_OSC_EDGES) m_edges = '0;           // Any write clears
        if (a == ADDR_CLK_DIV) begin
            if (d > 32'h0000_FFFF) m_div = 16'hFFFF;     // Saturate
            else if (d < {16'h0000, BASE_DIV_MIN}) m_div = BASE_DIV_MIN;
            else m_div = d[DIV_W-1:0];
        end
    endtask

    task automatic bus_read(input addr_t a);
        @(negedge sys_clk);
        opb_addr = a;
        opb_we   = 1'b0;
        opb_re   = 1'b1;
        exp_q.push_back(expected_read(a));
    endtask

    task automatic bus_idle();
        @(negedge sys_clk);
        opb_we = 1'b0;
        opb_re = 1'b0;
    endtask

    task automatic drain_reads();
        while (exp_q.size() != 0) @(negedge sys_clk);
    endtask

    // Waits for a strobe or a wd_trig toggle, returns its cycle
    task automatic wait_event(input int sel, output int at_cycle);
        logic seen;
        logic wd_prev;
        wd_prev = wd_trig;
        seen = 1'b0;
        while (!seen) begin
            @(negedge sys_clk);
            case (sel)
                EV_20K:  seen = dbg_clk_20khz;
                EV_2K:   seen = dbg_clk_2khz;
                default: seen = (wd_trig != wd_prev);
            endcase
        end
        at_cycle = cycles;
    endtask

    // ------------------------------------------------------------------------
    // Read return monitor and run limit
    // ------------------------------------------------------------------------
    always @(negedge sys_clk) begin
        if (!rst && opb_rvalid) begin
            if (exp_q.size() == 0) begin
                stop_run("read data returned with no read outstanding");
            end else begin
                exp_word = exp_q.pop_front();            // Oldest read first
                check("opb_rdata", opb_rdata, exp_word);
            end
        end
    end

    always @(posedge sys_clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) stop_run("timeout, the run did not finish in time");
    end

    // ------------------------------------------------------------------------
    // Tests
    // ------------------------------------------------------------------------
    task automatic sp_traffic(input int n_ops);
        logic [31:0] r;
        addr_t       a;
        for (int i = 0; i < n_ops; i++) begin
            r = rand32();
            a = r[1] ? ADDR_SP2 : ADDR_SP1;
            if (r[0]) bus_write(a, rand32());
            else bus_read(a);
            if (r[4:2] == 3'd0) bus_idle();              // Occasional gap
        end
        bus_read(ADDR_SP1);                              // Back-to-back burst
        bus_read(ADDR_SP2);
        bus_read(ADDR_SP1);
        bus_read(ADDR_SP2);
        bus_idle();
        drain_reads();
    endtask

    task automatic map_reads(input int n);
        addr_t a;
        bus_read(ADDR_VERSION);
        for (int i = 0; i < n; i++) begin
            a = addr_t'(rand32());
            if (a[1:0] == 2'b00 && a <= ADDR_VERSION) a[7] = 1'b1; // Move off the map
            bus_read(a);
        end
        bus_idle();
        drain_reads();
    endtask

    task automatic osc_test();
        int period;
        int high;
        period = 4 + int'(rand32() % 16);
        high = period / 2;
        bus_write(ADDR_OSC_EDGES, rand32());
        bus_idle();
        for (int e = 0; e < N_OSC_EDGES; e++) begin
            @(negedge sys_clk);
            ref_clk = 1'b1;
            repeat (high - 1) @(negedge sys_clk);
            @(negedge sys_clk);
            ref_clk = 1'b0;
            repeat (period - high - 1) @(negedge sys_clk);
        end
        m_period = period;
        m_edges = N_OSC_EDGES;
        repeat (5) bus_idle();                           // Synchronizer latency
        bus_read(ADDR_OSC_PERIOD);
        bus_read(ADDR_OSC_EDGES);
        bus_write(ADDR_OSC_EDGES, rand32());
        bus_read(ADDR_OSC_EDGES);
        bus_idle();
        drain_reads();
    endtask

    task automatic div_test(input int span);
        int t1;
        int t2;
        bus_write(ADDR_CLK_DIV, rand32() % span);
        bus_read(ADDR_CLK_DIV);                          // Clamped readback
        bus_idle();
        drain_reads();
        wait_event(EV_20K, t1);
        wait_event(EV_20K, t2);
        check("dbg_clk_20khz spacing", t2 - t1, DECADE * m_div);
        wait_event(EV_2K, t1);
        wait_event(EV_2K, t2);
        check("dbg_clk_2khz spacing", t2 - t1, DECADE * DECADE * m_div);
    endtask

    task automatic wd_test();
        int t1;
        int t2;
        bus_write(ADDR_CLK_DIV, 2 + (rand32() % (MAX_WD_DIV - 1)));
        bus_idle();
        wait_event(EV_WD, t1);                           // First toggle may be partial
        wait_event(EV_WD, t2);
        check("wd_trig spacing", t2 - t1, DECADE * DECADE * WD_PULSES * m_div);
    endtask

    initial begin
        opb_addr  = '0;
        opb_wdata = '0;
        opb_we    = 1'b0;
        opb_re    = 1'b0;
        ref_clk   = 1'b0;
        rst       = 1'b1;
        m_sp1     = '0;
        m_sp2     = '0;
        m_div     = BASE_DIV_RESET;
        m_period  = '0;
        m_edges   = '0;
        rng_state = 32'd13;
        repeat (RST_CYCLES) @(negedge sys_clk);
        rst = 1'b0;

        check("wd_trig", {31'b0, wd_trig}, 32'h0);
        check("dbg_clk_2khz", {31'b0, dbg_clk_2khz}, 32'h0);
        bus_read(ADDR_SP1);                              // Reset values
        bus_read(ADDR_SP2);
        bus_read(ADDR_CLK_DIV);
        bus_read(ADDR_OSC_PERIOD);
        bus_read(ADDR_OSC_EDGES);
        bus_idle();
        drain_reads();

        sp_traffic(N_SP_OPS);
        map_reads(N_UNMAPPED);
        osc_test();
        div_test(2);                                     // 0 or 1, always clamped
        div_test(MAX_DIV + 1);
        wd_test();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

//--- test/ctrl_top_sva.sv
`timescale 1ns/1ps

module ctrl_top_sva (
    input logic sys_clk,
    input logic rst,
    input logic opb_re,
    input logic opb_rvalid,
    input logic pulse_200k,
    input logic dbg_clk_20khz,
    input logic dbg_clk_2khz,
    input logic wd_trig
);

    // ------------------------------------------------------------------------
    // Bus read timing
    // ------------------------------------------------------------------------
    rvalid_after_re: assert property (@(posedge sys_clk) disable iff (rst)
        opb_re |=> opb_rvalid)
        else $error("opb_rvalid missing one cycle after opb_re");

    // Valid lasts one cycle unless another read follows
    rvalid_one_cycle: assert property (@(posedge sys_clk) disable iff (rst)
        $past(opb_re) && !opb_re |=> !opb_rvalid)
        else $error("opb_rvalid held without a new read");

    // ------------------------------------------------------------------------
    // Reset state
    // ------------------------------------------------------------------------
    quiet_in_reset: assert property (@(posedge sys_clk)
        rst |=> !pulse_200k && !dbg_clk_20khz && !dbg_clk_2khz && !wd_trig && !opb_rvalid)
        else $error("strobe or wd_trig high during reset");

endmodule

bind ctrl_top ctrl_top_sva u_sva (
    .sys_clk       (sys_clk),
    .rst           (rst),
    .opb_re        (opb_re),
    .opb_rvalid    (opb_rvalid),
    .pulse_200k    (pulse_200k),
    .dbg_clk_20khz (dbg_clk_20khz),
    .dbg_clk_2khz  (dbg_clk_2khz),
    .wd_trig       (wd_trig)
);

//--- verilog/ctrl_top.sv
`timescale 1ns/1ps

module ctrl_top import ctrl_pkg::*; (
    input  logic  sys_clk,
    input  logic  rst,

    // Register bus
    input  addr_t opb_addr,
    input  data_t opb_wdata,
    input  logic  opb_we,
    input  logic  opb_re,
    output data_t opb_rdata,
    output logic  opb_rvalid,

    input  logic  ref_clk,                               // Reference for period counter
    output logic  wd_trig,                               // Watchdog kick
    output logic  dbg_clk_20khz,                         // Debug header
    output logic  dbg_clk_2khz                           // Debug header, also paces watchdog
);

    // ------------------------------------------------------------------------
    // Internal wiring
    // ------------------------------------------------------------------------
    logic             sp_we;                             // Decoder strobes
    logic             sp_sel;
    logic             div_we;
    logic             osc_clr;
    data_t            sp1;                               // Register values to decoder
    data_t            sp2;
    logic [DIV_W-1:0] base_div;
    data_t            osc_period;
    data_t            osc_edges;
    logic             pulse_200k;                        // Base strobe

    opb_decode u_decode (
        .sys_clk    (sys_clk),
        .rst        (rst),
        .opb_addr   (opb_addr),
        .opb_we     (opb_we),
        .opb_re     (opb_re),
        .sp1        (sp1),
        .sp2        (sp2),
        .base_div   (base_div),
        .osc_period (osc_period),
        .osc_edges  (osc_edges),
        .sp_we      (sp_we),
        .sp_sel     (sp_sel),
        .div_we     (div_we),
        .osc_clr    (osc_clr),
        .opb_rdata  (opb_rdata),
        .opb_rvalid (opb_rvalid)
    );

    pulse_gen u_pulse_gen (
        .sys_clk    (sys_clk),
        .rst        (rst),
        .div_we     (div_we),
        .opb_wdata  (opb_wdata),
        .base_div   (base_div),
        .pulse_200k (pulse_200k),
        .pulse_20k  (dbg_clk_20khz),
        .pulse_2k   (dbg_clk_2khz)
    );

    osc_counter u_osc_counter (
        .sys_clk    (sys_clk),
        .rst        (rst),
        .ref_clk    (ref_clk),
        .osc_clr    (osc_clr),
        .osc_period (osc_period),
        .osc_edges  (osc_edges)
    );

    scratch_pad u_scratch_pad (
        .sys_clk    (sys_clk),
        .rst        (rst),
        .sp_we      (sp_we),
        .sp_sel     (sp_sel),
        .opb_wdata  (opb_wdata),
        .sp1        (sp1),
        .sp2        (sp2)
    );

    watchdog u_watchdog (
        .sys_clk    (sys_clk),
        .rst        (rst),
        .pulse_2k   (dbg_clk_2khz),
        .wd_trig    (wd_trig)
    );

endmodule

//--- verilog/watchdog.sv
`timescale 1ns/1ps

module watchdog import ctrl_pkg::*; (
    input  logic sys_clk,
    input  logic rst,
    input  logic pulse_2k,                               // Pacing strobe
    output logic wd_trig                                 // To external watchdog
);

    logic [WD_W-1:0] strobe_cnt;                         // 2 kHz strobes since last toggle
    logic            cnt_end;

    assign cnt_end = (strobe_cnt == WD_W'(WD_PULSES - 1));

    // Toggle every WD_PULSES strobes
    // a stalled pulse chain lets the external watchdog expire
    always_ff @(posedge sys_clk) begin
        if (rst) begin
            strobe_cnt <= '0;
            wd_trig    <= 1'b0;
        end else if (pulse_2k) begin
            if (cnt_end) begin
                strobe_cnt <= '0;
                wd_trig    <= !wd_trig;
            end else begin
                strobe_cnt <= strobe_cnt + 1'b1;
            end
        end
    end

endmodule

//--- verilog/scratch_pad.sv
`timescale 1ns/1ps

module scratch_pad import ctrl_pkg::*; (
    input  logic  sys_clk,
    input  logic  rst,
    input  logic  sp_we,                                 // Write to either word
    input  logic  sp_sel,                                // 0 = sp1, 1 = sp2
    input  data_t opb_wdata,
    output data_t sp1,
    output data_t sp2
);

    // Two plain read/write words for bus sanity checks
    always_ff @(posedge sys_clk) begin
        if (rst) begin
            sp1 <= '0;
            sp2 <= '0;
        end else if (sp_we) begin
            if (sp_sel) begin
                sp2 <= opb_wdata;
            end else begin
                sp1 <= opb_wdata;
            end
        end
    end

endmodule

//--- verilog/osc_counter.sv
`timescale 1ns/1ps

module osc_counter import ctrl_pkg::*; (
    input  logic  sys_clk,
    input  logic  rst,
    input  logic  ref_clk,                               // External 2 kHz reference, async
    input  logic  osc_clr,                               // Clears edge count
    output data_t osc_period,                            // Cycles between last two edges
    output data_t osc_edges                              // Rising edges seen
);

    logic  ref_meta;                                     // First synchronizer stage
    logic  ref_sync;                                     // Second synchronizer stage
    logic  ref_prev;                                     // For edge detect
    logic  ref_rise;
    data_t cycle_cnt;                                    // Cycles since last edge

    // ------------------------------------------------------------------------
    // Synchronizer and edge detect
    // ------------------------------------------------------------------------
    always_ff @(posedge sys_clk) begin
        if (rst) begin
            ref_meta <= 1'b0;
            ref_sync <= 1'b0;
            ref_prev <= 1'b0;
        end else begin
            ref_meta <= ref_clk;
            ref_sync <= ref_meta;
            ref_prev <= ref_sync;
        end
    end

    assign ref_rise = ref_sync && !ref_prev;             // Fixed latency after the pin

    // ------------------------------------------------------------------------
    // Period measurement
    // ------------------------------------------------------------------------
    // Count is 1 the cycle after an edge, so it equals the period at the next edge
    always_ff @(posedge sys_clk) begin
        if (rst) begin
            cycle_cnt  <= '0;
            osc_period <= '0;
        end else if (ref_rise) begin
            osc_period <= cycle_cnt;
            cycle_cnt  <= data_t'(1);
        end else if (cycle_cnt != '1) begin
            cycle_cnt  <= cycle_cnt + 1'b1;              // Saturate if reference stops
        end
    end

    // ------------------------------------------------------------------------
    // Edge count
    // ------------------------------------------------------------------------
    always_ff @(posedge sys_clk) begin
        if (rst || osc_clr) begin                        // Clear wins over a same-cycle edge
            osc_edges <= '0;
        end else if (ref_rise) begin
            osc_edges <= osc_edges + 1'b1;
        end
    end

endmodule

//--- verilog/pulse_gen.sv
`timescale 1ns/1ps

module pulse_gen import ctrl_pkg::*; (
    input  logic             sys_clk,
    input  logic             rst,
    input  logic             div_we,                     // Divider write strobe
    input  data_t            opb_wdata,
    output logic [DIV_W-1:0] base_div,                   // Current divider
    output logic             pulse_200k,
    output logic             pulse_20k,
    output logic             pulse_2k
);

    logic [DIV_W-1:0]    wr_div;                         // Incoming divider, saturated
    logic [DIV_W-1:0]    wr_div_clamped;
    logic [DIV_W-1:0]    base_cnt;                       // Cycles within base period
    logic [DECADE_W-1:0] dec1_cnt;                       // 200k strobes within 20k period
    logic [DECADE_W-1:0] dec2_cnt;                       // 20k strobes within 2k period
    logic                base_end;
    logic                dec1_end;
    logic                dec2_end;

    // ------------------------------------------------------------------------
    // Divider register
    // ------------------------------------------------------------------------
    // Too large for DIV_W saturates, too small clamps up
    assign wr_div = (|opb_wdata[DATA_W-1:DIV_W]) ? '1 : opb_wdata[DIV_W-1:0];
    assign wr_div_clamped = (wr_div < BASE_DIV_MIN) ? BASE_DIV_MIN : wr_div;

    always_ff @(posedge sys_clk) begin
        if (rst) begin
            base_div <= BASE_DIV_RESET;
        end else if (div_we) begin
            base_div <= wr_div_clamped;
        end
    end

    // ------------------------------------------------------------------------
    // Strobe chain
    // ------------------------------------------------------------------------
    assign base_end = (base_cnt == base_div - 1'b1);     // Last cycle of base period
    assign dec1_end = (dec1_cnt == DECADE_W'(DECADE - 1));
    assign dec2_end = (dec2_cnt == DECADE_W'(DECADE - 1));

    always_ff @(posedge sys_clk) begin
        if (rst || div_we) begin                         // New divider restarts chain
            base_cnt   <= '0;
            dec1_cnt   <= '0;
            dec2_cnt   <= '0;
            pulse_200k <= 1'b0;
            pulse_20k  <= 1'b0;
            pulse_2k   <= 1'b0;
        end else begin
            pulse_200k <= base_end;
            pulse_20k  <= base_end && dec1_end;          // Aligned with a 200k strobe
            pulse_2k   <= base_end && dec1_end && dec2_end; // Aligned with a 20k strobe

            if (base_end) begin
                base_cnt <= '0;
                if (dec1_end) begin
                    dec1_cnt <= '0;
                    if (dec2_end) begin
                        dec2_cnt <= '0;
                    end else begin
                        dec2_cnt <= dec2_cnt + 1'b1;
                    end
                end else begin
                    dec1_cnt <= dec1_cnt + 1'b1;
                end
            end else begin
                base_cnt <= base_cnt + 1'b1;
            end
        end
    end

endmodule

//--- verilog/opb_decode.sv
`timescale 1ns/1ps

module opb_decode import ctrl_pkg::*; (
    input  logic             sys_clk,
    input  logic             rst,

    // Bus from outside
    input  addr_t            opb_addr,
    input  logic             opb_we,                     // One-cycle write strobe
    input  logic             opb_re,                     // One-cycle read strobe

    // Register values from the blocks
    input  data_t            sp1,
    input  data_t            sp2,
    input  logic [DIV_W-1:0] base_div,
    input  data_t            osc_period,
    input  data_t            osc_edges,

    // Write strobes to the blocks
    output logic             sp_we,
    output logic             sp_sel,                     // 1 = scratchpad 2
    output logic             div_we,
    output logic             osc_clr,

    // Read return
    output data_t            opb_rdata,
    output logic             opb_rvalid
);

    data_t rd_mux;                                       // Selected read word

    // ------------------------------------------------------------------------
    // Write decode
    // ------------------------------------------------------------------------
    assign sp_sel  = (opb_addr == ADDR_SP2);
    assign sp_we   = opb_we && ((opb_addr == ADDR_SP1) || sp_sel);
    assign div_we  = opb_we && (opb_addr == ADDR_CLK_DIV);
    assign osc_clr = opb_we && (opb_addr == ADDR_OSC_EDGES); // Clear on any write

    // ------------------------------------------------------------------------
    // Read path
    // ------------------------------------------------------------------------
    always_comb begin
        case (opb_addr)
            ADDR_SP1:        rd_mux = sp1;
            ADDR_SP2:        rd_mux = sp2;
            ADDR_CLK_DIV:    rd_mux = {{(DATA_W-DIV_W){1'b0}}, base_div}; // Zero extend
            ADDR_OSC_PERIOD: rd_mux = osc_period;
            ADDR_OSC_EDGES:  rd_mux = osc_edges;
            ADDR_VERSION:    rd_mux = VERSION_ID;
            default:         rd_mux = UNMAPPED_DATA;
        endcase
    end

    // Data one cycle after the strobe, no wait states
    always_ff @(posedge sys_clk) begin
        if (rst) begin
            opb_rdata  <= '0;
            opb_rvalid <= 1'b0;
        end else begin
            opb_rvalid <= opb_re;                        // Exactly one cycle per read
            if (opb_re) begin
                opb_rdata <= rd_mux;                     // Hold until next read
            end
        end
    end

endmodule

//--- verilog/ctrl_pkg.sv
package ctrl_pkg;

    // ------------------------------------------------------------------------
    // Bus widths and types
    // ------------------------------------------------------------------------
    localparam int DATA_W = 32;                          // Bus data width
    localparam int ADDR_W = 8;                           // Bus byte address width

    typedef logic [DATA_W-1:0] data_t;                   // One bus word
    typedef logic [ADDR_W-1:0] addr_t;                   // One bus address

    // ------------------------------------------------------------------------
    // Register map
    // ------------------------------------------------------------------------
    localparam addr_t ADDR_SP1        = 8'h00;           // Scratchpad 1
    localparam addr_t ADDR_SP2        = 8'h04;           // Scratchpad 2
    localparam addr_t ADDR_CLK_DIV    = 8'h08;           // Base divider
    localparam addr_t ADDR_OSC_PERIOD = 8'h0C;           // Last ref period
    localparam addr_t ADDR_OSC_EDGES  = 8'h10;           // Ref edge count, write clears
    localparam addr_t ADDR_VERSION    = 8'h14;           // Read only

    localparam data_t VERSION_ID    = 32'h0002_0104;     // Core version word
    localparam data_t UNMAPPED_DATA = 32'hDEAD_BEEF;     // Returned for holes in the map

    // ------------------------------------------------------------------------
    // Pulse generator
    // ------------------------------------------------------------------------
    localparam int DIV_W = 16;                           // Base divider width

    // 100 MHz / 500 gives the 200 kHz base strobe
    localparam logic [DIV_W-1:0] BASE_DIV_RESET = 16'd500;
    localparam logic [DIV_W-1:0] BASE_DIV_MIN   = 16'd2; // Shorter would stall the strobe

    localparam int DECADE   = 10;                        // 200k -> 20k -> 2k
    localparam int DECADE_W = $clog2(DECADE);            // Decade counter width

    // ------------------------------------------------------------------------
    // Watchdog
    // ------------------------------------------------------------------------
    localparam int WD_PULSES = 4;                        // 2 kHz strobes per toggle
    localparam int WD_W      = $clog2(WD_PULSES);        // Strobe counter width

endpackage
